// File: run.sh
#!/bin/sh
# build the mailbox testbench with Verilator and run it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --assert --timescale 1ns/1ns \
  -f tb.f --top-module tb_mbox -Mdir "$BUILD_DIR" -o tb_mbox
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/tb_mbox"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi
exit 0

// File: source/mbox_fifo.sv
// mailbox FIFO
// circular buffer holding one direction's messages
// push and pop act at the sampling edge, either flush empties it and
// overrides both; the head word is shown combinationally

`timescale 1ns/1ns

module mbox_fifo (
  input logic        clk_i,
  input logic        reset_i,
  mbox_fifo_if.store fifo
);
  import mbox_pkg::*;

  typedef logic [$clog2(DEPTH)-1:0] ptr_t;

  ptr_t   wr_ptr_q;           // next slot to fill
  ptr_t   rd_ptr_q;           // head slot
  count_t count_q;            // occupancy
  data_t  mem_q [DEPTH];      // message storage
  logic   flush;
  logic   do_push;
  logic   do_pop;

  // wrap a pointer at the end of the buffer
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign flush   = fifo.w_flush | fifo.r_flush;  // either side may flush
  assign do_push = fifo.push & ~fifo.full;       // writer already checks full
  assign do_pop  = fifo.pop & ~fifo.empty;

  // ------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush) begin
      wr_ptr_q <= '0;  // flush beats push and pop
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or push and pop together
      endcase
    end
  end

  // storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (do_push && !flush) begin
      mem_q[wr_ptr_q] <= fifo.wdata;
    end
  end

  // flags and head word
  assign fifo.full  = (count_q == count_t'(DEPTH));
  assign fifo.empty = (count_q == '0);
  assign fifo.count = count_q;
  assign fifo.rdata = mem_q[rd_ptr_q];  // only meaningful while not empty

endmodule

// File: source/mbox_fifo_if.sv
// mailbox FIFO interface
// carries one direction of the mailbox, from the writing port through
// the FIFO to the reading port; strobes only, no handshake

`timescale 1ns/1ns

interface mbox_fifo_if;
  import mbox_pkg::*;

  // writer side
  logic   push;     // one-cycle pulse, only while not full
  data_t  wdata;    // word to push
  logic   w_flush;  // flush request from the writer

  // reader side
  logic   pop;      // one-cycle pulse, only while not empty
  logic   r_flush;  // flush request from the reader

  // store side
  logic   full;
  logic   empty;
  count_t count;    // occupancy 0..DEPTH
  data_t  rdata;    // head word, valid while not empty

  // port that fills this direction
  modport writer (output push, wdata, w_flush, input full, count);

  // port that drains this direction
  modport reader (output pop, r_flush, input empty, count, rdata);

  // the FIFO itself
  modport store (
    input  push, wdata, w_flush, pop, r_flush,
    output full, empty, count, rdata
  );

endinterface

// File: source/mbox_pkg.sv
// mailbox package
// shared sizes, types and constants for the two-port mailbox
// register indices, interrupt bit names, status bit positions and the
// fixed read patterns returned by the data registers

package mbox_pkg;

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------
  localparam int unsigned DATA_WIDTH  = 32;  // mailbox word and register data
  localparam int unsigned DEPTH       = 8;   // words per direction
  localparam int unsigned COUNT_WIDTH = $clog2(DEPTH + 1);  // holds 0..DEPTH
  localparam int unsigned NUM_PORTS   = 2;   // one port per agent

  typedef logic [DATA_WIDTH-1:0]  data_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // ------------------------------------------------------------
  // register map, index is the address
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    MBOXW  = 4'd0,  // push a word towards the other agent
    MBOXR  = 4'd1,  // pop a word sent by the other agent
    STATUS = 4'd2,  // read only
    ERROR  = 4'd3,  // sticky, cleared on read
    WIRQT  = 4'd4,  // write fill threshold
    RIRQT  = 4'd5,  // read fill threshold
    IRQS   = 4'd6,  // interrupt status, write one to ack
    IRQEN  = 4'd7,  // interrupt enable
    IRQP   = 4'd8,  // pending = status & enable, read only
    CTRL   = 4'd9   // flush strobes
  } reg_idx_e;

  // bit positions inside IRQS, IRQEN and IRQP
  typedef enum logic [1:0] {
    IRQ_WRITE = 2'd0,
    IRQ_READ  = 2'd1,
    IRQ_ERROR = 2'd2
  } irq_bit_e;

  // bit positions inside the status word
  localparam int unsigned STATUS_EMPTY = 0;  // read side has nothing to pop
  localparam int unsigned STATUS_FULL  = 1;  // write side cannot take a word
  localparam int unsigned STATUS_WTHR  = 2;  // write fill above WIRQT
  localparam int unsigned STATUS_RTHR  = 3;  // read fill above RIRQT

  // fixed read data
  localparam data_t WRITE_ONLY_PATTERN = 32'hFEEDC0DE;  // MBOXW read
  localparam data_t EMPTY_READ_PATTERN = 32'hFEEDDEAD;  // MBOXR read while empty

endpackage

// File: source/mbox_port_regs.sv
// mailbox port register file
// one agent's view of the mailbox: pushes into tx, pops from rx
// decodes the strobe bus, keeps error, threshold and interrupt state
// read data, valid and error are registered; irq is a level from regs

`timescale 1ns/1ns

module mbox_port_regs (
  input  logic               clk_i,
  input  logic               reset_i,
  // write access
  input  logic               wr_en_i,
  input  mbox_pkg::reg_idx_e wr_idx_i,
  input  mbox_pkg::data_t    wr_data_i,
  // read access
  input  logic               rd_en_i,
  input  mbox_pkg::reg_idx_e rd_idx_i,
  output mbox_pkg::data_t    rd_data_o,
  output logic               rd_valid_o,
  output logic               rd_err_o,
  output logic               wr_err_o,
  output logic               irq_o,       // active high level
  mbox_fifo_if.writer        tx,          // towards the other agent
  mbox_fifo_if.reader        rx           // from the other agent
);
  import mbox_pkg::*;

  logic [3:0] status;                // read only, built from FIFO flags
  logic [1:0] error_q,  error_d;     // bit 0 empty read, bit 1 full write
  count_t     wirqt_q,  wirqt_d;     // write threshold
  count_t     rirqt_q,  rirqt_d;     // read threshold
  logic [2:0] irqs_q,   irqs_d;      // interrupt status
  logic [2:0] irqen_q,  irqen_d;     // interrupt enable
  logic [2:0] irqp;                  // pending view
  logic [2:0] irq_ack;               // ones written to IRQS
  logic [1:0] new_err;               // errors raised this cycle
  logic       err_clr;               // ERROR read this cycle
  data_t      rd_data_d;
  logic       rd_err_d;
  logic       wr_err_d;

  // thresholds above the top fill level make no sense
  function automatic count_t clamp_thr(input data_t value);
    if (value >= data_t'(DEPTH)) begin
      return count_t'(DEPTH - 1);
    end
    return count_t'(value);
  endfunction

  always_comb begin
    status               = '0;
    status[STATUS_EMPTY] = rx.empty;
    status[STATUS_FULL]  = tx.full;
    status[STATUS_WTHR]  = tx.count > wirqt_q;  // strictly above
    status[STATUS_RTHR]  = rx.count > rirqt_q;
  end

  assign irqp     = irqs_q & irqen_q;
  assign irq_o    = |irqp;
  assign tx.wdata = wr_data_i;  // only taken on a push

  // ------------------------------------------------------------
  // access decode, read and write share one block so a new error
  // can win over a clear in the same cycle
  // ------------------------------------------------------------
  always_comb begin
    tx.push    = 1'b0;
    tx.w_flush = 1'b0;
    rx.pop     = 1'b0;
    rx.r_flush = 1'b0;
    wirqt_d    = wirqt_q;
    rirqt_d    = rirqt_q;
    irqen_d    = irqen_q;
    irq_ack    = '0;
    new_err    = '0;
    err_clr    = 1'b0;
    rd_data_d  = '0;
    rd_err_d   = 1'b0;
    wr_err_d   = 1'b0;

    // read side
    if (rd_en_i) begin
      case (rd_idx_i)
        MBOXW:  rd_data_d = WRITE_ONLY_PATTERN;
        MBOXR: begin
          if (!rx.empty) begin
            rd_data_d = rx.rdata;
            rx.pop    = 1'b1;          // pops at this edge
          end else begin
            rd_data_d  = EMPTY_READ_PATTERN;
            rd_err_d   = 1'b1;
            new_err[0] = 1'b1;
          end
        end
        STATUS: rd_data_d = data_t'(status);
        ERROR: begin
          rd_data_d = data_t'(error_q);
          err_clr   = 1'b1;            // clear on read
        end
        WIRQT:  rd_data_d = data_t'(wirqt_q);
        RIRQT:  rd_data_d = data_t'(rirqt_q);
        IRQS:   rd_data_d = data_t'(irqs_q);
        IRQEN:  rd_data_d = data_t'(irqen_q);
        IRQP:   rd_data_d = data_t'(irqp);
        CTRL:   rd_data_d = '0;        // flush is a pulse, nothing to show
        default: rd_err_d = 1'b1;      // index 10 and up
      endcase
    end

    // write side
    if (wr_en_i) begin
      case (wr_idx_i)
        MBOXW: begin
          if (!tx.full) begin
            tx.push = 1'b1;
          end else begin
            wr_err_d   = 1'b1;         // word is dropped
            new_err[1] = 1'b1;
          end
        end
        WIRQT:  wirqt_d = clamp_thr(wr_data_i);
        RIRQT:  rirqt_d = clamp_thr(wr_data_i);
        IRQS:   irq_ack = wr_data_i[2:0];  // write one to ack
        IRQEN:  irqen_d = wr_data_i[2:0];
        CTRL: begin
          rx.r_flush = wr_data_i[1];
          tx.w_flush = wr_data_i[0];
        end
        MBOXR, STATUS, ERROR, IRQP: ;  // read only, ignored quietly
        default: wr_err_d = 1'b1;      // index 10 and up
      endcase
    end

    // merge, new events after clears
    error_d = (err_clr ? 2'b00 : error_q) | new_err;
    irqs_d  = irqs_q & ~irq_ack;
    if (status[STATUS_WTHR]) irqs_d[IRQ_WRITE] = 1'b1;
    if (status[STATUS_RTHR]) irqs_d[IRQ_READ]  = 1'b1;
    if (|new_err)            irqs_d[IRQ_ERROR] = 1'b1;
  end

  // ------------------------------------------------------------
  // state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      error_q    <= '0;
      wirqt_q    <= '0;
      rirqt_q    <= '0;
      irqs_q     <= '0;
      irqen_q    <= '0;
      rd_valid_o <= 1'b0;
      rd_err_o   <= 1'b0;
      wr_err_o   <= 1'b0;
    end else begin
      error_q    <= error_d;
      wirqt_q    <= wirqt_d;
      rirqt_q    <= rirqt_d;
      irqs_q     <= irqs_d;
      irqen_q    <= irqen_d;
      rd_valid_o <= rd_en_i;   // one pulse per read
      rd_err_o   <= rd_err_d;
      wr_err_o   <= wr_err_d;
    end
  end

  // read data, only loaded on an access
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= rd_data_d;
    end
  end

endmodule

// File: source/mbox_top.sv
// two-port mailbox, top level
// each agent owns a register port; a word written by one agent is
// queued and popped by the other
// port i fills FIFO i and drains FIFO 1-i

`timescale 1ns/1ns

module mbox_top (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  // write strobes, one lane per agent
  input  logic               [mbox_pkg::NUM_PORTS-1:0] wr_en_i,
  input  mbox_pkg::reg_idx_e [mbox_pkg::NUM_PORTS-1:0] wr_idx_i,
  input  mbox_pkg::data_t    [mbox_pkg::NUM_PORTS-1:0] wr_data_i,
  output logic               [mbox_pkg::NUM_PORTS-1:0] wr_err_o,
  // read strobes and registered response
  input  logic               [mbox_pkg::NUM_PORTS-1:0] rd_en_i,
  input  mbox_pkg::reg_idx_e [mbox_pkg::NUM_PORTS-1:0] rd_idx_i,
  output mbox_pkg::data_t    [mbox_pkg::NUM_PORTS-1:0] rd_data_o,
  output logic               [mbox_pkg::NUM_PORTS-1:0] rd_valid_o,
  output logic               [mbox_pkg::NUM_PORTS-1:0] rd_err_o,
  // level interrupts, active high
  output logic               [mbox_pkg::NUM_PORTS-1:0] irq_o
);
  import mbox_pkg::*;

  // one interface per direction, index is the writing agent
  mbox_fifo_if u_fifo_if [NUM_PORTS] ();

  // ------------------------------------------------------------
  // per agent: its outgoing FIFO and its register port
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port

    mbox_fifo u_fifo (
      .clk_i   ( clk_i        ),
      .reset_i ( reset_i      ),
      .fifo    ( u_fifo_if[i] )   // words sent by agent i
    );

    mbox_port_regs u_port_regs (
      .clk_i      ( clk_i                      ),
      .reset_i    ( reset_i                    ),
      .wr_en_i    ( wr_en_i[i]                 ),
      .wr_idx_i   ( wr_idx_i[i]                ),
      .wr_data_i  ( wr_data_i[i]               ),
      .rd_en_i    ( rd_en_i[i]                 ),
      .rd_idx_i   ( rd_idx_i[i]                ),
      .rd_data_o  ( rd_data_o[i]               ),
      .rd_valid_o ( rd_valid_o[i]              ),
      .rd_err_o   ( rd_err_o[i]                ),
      .wr_err_o   ( wr_err_o[i]                ),
      .irq_o      ( irq_o[i]                   ),
      .tx         ( u_fifo_if[i]               ),  // own outgoing direction
      .rx         ( u_fifo_if[NUM_PORTS - 1 - i] )  // the other agent's words
    );

  end

endmodule

// File: tb.f
source/mbox_pkg.sv
source/mbox_fifo_if.sv
source/mbox_fifo.sv
source/mbox_port_regs.sv
source/mbox_top.sv
testbench/tb_mbox.sv

// File: testbench/tb_mbox.sv
// mailbox testbench
// drives both agents' strobe buses through message passing, empty and
// full errors, status and flush, threshold and error interrupts, and
// invalid register indices; immediate assertions check each response

`timescale 1ns/1ns

module tb_mbox;
  import mbox_pkg::*;

  logic                     clk_i;
  logic                     reset_i;
  logic     [NUM_PORTS-1:0] wr_en_i;
  reg_idx_e [NUM_PORTS-1:0] wr_idx_i;
  data_t    [NUM_PORTS-1:0] wr_data_i;
  logic     [NUM_PORTS-1:0] wr_err_o;
  logic     [NUM_PORTS-1:0] rd_en_i;
  reg_idx_e [NUM_PORTS-1:0] rd_idx_i;
  data_t    [NUM_PORTS-1:0] rd_data_o;
  logic     [NUM_PORTS-1:0] rd_valid_o;
  logic     [NUM_PORTS-1:0] rd_err_o;
  logic     [NUM_PORTS-1:0] irq_o;

  data_t sent_q [$];     // words in flight, oldest first
  data_t exp_regs [10];  // port 0 register contents around the invalid accesses
  data_t word;
  data_t rdata;
  logic  err;

  mbox_top u_dut (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .wr_en_i    ( wr_en_i    ),
    .wr_idx_i   ( wr_idx_i   ),
    .wr_data_i  ( wr_data_i  ),
    .wr_err_o   ( wr_err_o   ),
    .rd_en_i    ( rd_en_i    ),
    .rd_idx_i   ( rd_idx_i   ),
    .rd_data_o  ( rd_data_o  ),
    .rd_valid_o ( rd_valid_o ),
    .rd_err_o   ( rd_err_o   ),
    .irq_o      ( irq_o      )
  );

  always #5 clk_i = ~clk_i;  // 10 ns period

  // ------------------------------------------------------------
  // checks and bus tasks
  // ------------------------------------------------------------
  task automatic compare_word(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      $display("sim failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // one write strobe, returns the error pulse of the following cycle
  task automatic reg_write(input int port, input reg_idx_e idx, input data_t data,
                           output logic werr);
    @(negedge clk_i);
    wr_en_i[port]   = 1'b1;
    wr_idx_i[port]  = idx;
    wr_data_i[port] = data;
    @(negedge clk_i);
    wr_en_i[port] = 1'b0;
    werr          = wr_err_o[port];
  endtask

  // one read strobe, waits for the valid pulse
  task automatic reg_read(input int port, input reg_idx_e idx, output data_t data,
                          output logic rerr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rd_en_i[port]  = 1'b1;
    rd_idx_i[port] = idx;
    @(negedge clk_i);
    rd_en_i[port] = 1'b0;
    while (!rd_valid_o[port]) begin
      if (waited == 8) begin
        $display("port %0d gave no read response", port);
        $display("sim failed");
        $fatal(1, "read response timeout");
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
    data = rd_data_o[port];
    rerr = rd_err_o[port];
  endtask

  // six tests at up to 200 cycles each, margin for reset
  initial begin
    repeat (6 * 200 + 100) @(posedge clk_i);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1, "watchdog timeout");
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    wr_en_i   = '0;
    wr_data_i = '0;
    rd_en_i   = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      wr_idx_i[p] = MBOXW;
      rd_idx_i[p] = MBOXW;
    end
    void'($urandom(50));
    repeat (3) @(posedge clk_i);  // reset held for three edges
    @(negedge clk_i);
    reset_i = 1'b0;

    reg_read(0, STATUS, rdata, err);
    compare_word("status after reset", 32'h1, rdata);  // only empty

    // message passing, both directions
    for (int src = 0; src < NUM_PORTS; src++) begin
      for (int k = 0; k < DEPTH; k++) begin
        word = $urandom;
        sent_q.push_back(word);
        reg_write(src, MBOXW, word, err);
        check_flag("message push error", 1'b0, err);
      end
      for (int k = 0; k < DEPTH; k++) begin
        reg_read(1 - src, MBOXR, rdata, err);
        compare_word("message order", sent_q.pop_front(), rdata);
        check_flag("message pop error", 1'b0, err);
      end
    end

    // empty and full errors
    reg_read(1, MBOXR, rdata, err);
    compare_word("empty read data", EMPTY_READ_PATTERN, rdata);
    check_flag("empty read error", 1'b1, err);
    reg_read(1, ERROR, rdata, err);
    compare_word("error after empty read", 32'h1, rdata);
    reg_read(1, ERROR, rdata, err);
    compare_word("error cleared by read", 32'h0, rdata);
    for (int k = 0; k <= int'(DEPTH); k++) begin
      reg_write(0, MBOXW, data_t'(k), err);
      check_flag("fill write error", k == int'(DEPTH), err);  // only the extra word
    end
    reg_read(0, ERROR, rdata, err);
    compare_word("error after full write", 32'h2, rdata);
    reg_read(0, MBOXW, rdata, err);
    compare_word("write-only read data", WRITE_ONLY_PATTERN, rdata);
    check_flag("write-only read error", 1'b0, err);

    // status and flush, thresholds still zero
    reg_read(0, STATUS, rdata, err);
    compare_word("writer status when full", 32'h7, rdata);  // empty rx, full, above wirqt
    reg_read(1, STATUS, rdata, err);
    compare_word("reader status when full", 32'h8, rdata);  // above rirqt
    reg_write(0, CTRL, 32'h1, err);
    reg_read(1, STATUS, rdata, err);
    compare_word("reader status after flush", 32'h1, rdata);

    // write threshold interrupt
    reg_write(0, WIRQT, 32'd99, err);
    reg_read(0, WIRQT, rdata, err);
    compare_word("threshold clamp", data_t'(DEPTH - 1), rdata);
    reg_write(0, WIRQT, 32'd2, err);
    reg_write(0, IRQS, 32'h7, err);  // drop bits left by earlier tests
    reg_write(0, IRQEN, 32'h1, err);
    for (int k = 1; k <= 3; k++) begin
      reg_write(0, MBOXW, $urandom, err);
      wait_cycles(1);                // status bit lands one edge later
      check_flag("write irq after push", k == 3, irq_o[0]);
    end
    reg_read(0, IRQP, rdata, err);
    compare_word("pending write bit", 32'h1, rdata);
    reg_write(0, CTRL, 32'h1, err);  // count back to zero first
    reg_write(0, IRQS, 32'h1, err);
    check_flag("write irq after ack", 1'b0, irq_o[0]);

    // read threshold and error interrupt on port 1
    reg_write(1, RIRQT, 32'h1, err);
    reg_write(1, IRQS, 32'h7, err);
    reg_write(1, IRQEN, 32'h6, err);
    for (int k = 1; k <= 2; k++) begin
      word = $urandom;
      sent_q.push_back(word);
      reg_write(0, MBOXW, word, err);
      wait_cycles(1);
      check_flag("read irq after push", k == 2, irq_o[1]);
    end
    reg_read(1, IRQS, rdata, err);
    compare_word("read irq status", 32'h2, rdata);
    for (int k = 0; k < 2; k++) begin
      reg_read(1, MBOXR, rdata, err);
      compare_word("read irq word", sent_q.pop_front(), rdata);
    end
    reg_write(1, IRQS, 32'h2, err);
    check_flag("read irq after ack", 1'b0, irq_o[1]);
    reg_read(1, MBOXR, rdata, err);
    check_flag("empty read error for irq", 1'b1, err);
    reg_read(1, IRQS, rdata, err);
    compare_word("error irq status", 32'h4, rdata);
    check_flag("error irq", 1'b1, irq_o[1]);

    // invalid index, port 0 registers keep the state left by the tests above
    exp_regs[STATUS] = 32'h1;  // rx empty, both FIFOs drained
    exp_regs[ERROR]  = 32'h0;  // cleared by the read after the full write
    exp_regs[WIRQT]  = 32'h2;
    exp_regs[RIRQT]  = 32'h0;  // never written on port 0
    exp_regs[IRQS]   = 32'h0;  // acked after the flush
    exp_regs[IRQEN]  = 32'h1;  // write bit only
    exp_regs[IRQP]   = 32'h0;
    exp_regs[CTRL]   = 32'h0;  // always reads zero
    reg_write(0, reg_idx_e'(4'd10), 32'hFFFF_FFFF, err);
    check_flag("invalid write error", 1'b1, err);
    reg_read(0, reg_idx_e'(4'd11), rdata, err);
    check_flag("invalid read error", 1'b1, err);
    for (int i = 2; i < 10; i++) begin
      reg_read(0, reg_idx_e'(i[3:0]), rdata, err);
      compare_word("register after invalid access", exp_regs[i], rdata);
    end

    $display("sim passed");
    $finish;
  end

endmodule
